//--- project.f
verilog/mem_pkg.sv
verilog/addr_trans.sv
verilog/mem1_stage.sv
verilog/mem2_stage.sv
verilog/apb_arbiter.sv
verilog/apb_ram.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_props.sv
verification/mem_subsys_tb.sv

//--- verification/mem_subsys_tb.sv
`timescale 1ns/100ps

module mem_subsys_tb;

    localparam int K_ST  = 0;
    localparam int K_LD  = 1;
    localparam int K_ALU = 2;
    localparam int K_STF = 3;  // store killed by flush
    localparam int K_ALF = 4;  // alu op killed by flush
    localparam int K_LDX = 5;  // load arriving with an exception
    localparam mem_pkg::byte_type_e SZ_B = mem_pkg::BYTE;
    localparam mem_pkg::byte_type_e SZ_H = mem_pkg::HALF_WORD;
    localparam mem_pkg::byte_type_e SZ_W = mem_pkg::WORD;

    typedef struct packed {
        logic [2:0]          kind;
        mem_pkg::u32_t       va;      // alu result for alu kinds
        mem_pkg::byte_type_e bt;
        logic                sgn;
        mem_pkg::u32_t       wdata;
        mem_pkg::reg_idx_t   rd;
        mem_pkg::ecode_t     ecode;   // zero means no exception
        mem_pkg::u32_t       expd;
        logic                bp;
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   flush;
    logic                   wb_ready;
    mem_pkg::exe_mem_pass_t pass_in;
    mem_pkg::excp_t         excp_in;
    mem_pkg::trans_cfg_t    trans_cfg;
    mem_pkg::fetch_req_t    fetch_req;
    logic                   rdy_in;
    mem_pkg::fwd_t          fwd;
    mem_pkg::wb_t           wb_out;
    mem_pkg::excp_t         excp_out;
    mem_pkg::mem_resp_t     fetch_resp;

    row_t          tbl[$];
    int            exp_q[$];
    logic [7:0]    model_mem [0:1023];
    logic [31:0]   rng = 32'h526d_efb8;
    mem_pkg::u32_t fetch_exp;
    int            errors = 0;
    int            checks = 0;
    int            fetches = 0;
    int            cycles = 0;
    int            limit = 0;
    int            bp_left = 0;
    int            fwd_row = -1;
    logic          acc;
    logic          fetch_done = 1'b0;

    mem_subsys_top #(.RAM_WORDS(256)) dut_i (
        .clk, .rst_n, .flush, .pass_in, .excp_in, .trans_cfg, .wb_ready, .fetch_req,
        .rdy_in, .fwd, .wb_out, .excp_out, .fetch_resp
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] row_pc(input int i);
        return 32'h1c00_0000 + 32'(i) * 32'd4;
    endfunction

    function automatic logic is_load_kind(input logic [2:0] k);
        return (k == K_LD) || (k == K_LDX);
    endfunction

    function automatic logic is_flush_kind(input logic [2:0] k);
        return (k == K_STF) || (k == K_ALF);
    endfunction

    function automatic logic writes_rd(input logic [2:0] k);
        return is_load_kind(k) || (k == K_ALU) || (k == K_ALF);
    endfunction

    function automatic mem_pkg::u32_t model_word(input mem_pkg::u32_t pa);
        int a;
        a = int'(pa[9:0]);
        return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
    endfunction

    task automatic add_row(input int kind, input logic [31:0] va, input mem_pkg::byte_type_e bt,
                           input logic sgn, input logic [31:0] wdata, input logic [4:0] rd,
                           input logic [5:0] ecode, input logic [31:0] expd, input logic bp);
        tbl.push_back({3'(kind), va, bt, sgn, wdata, rd, ecode, expd, bp});
    endtask

    // segment 4 maps to segment 0, so the model index is the low va bits
    task automatic model_store(input row_t r);
        int a;
        a = int'(r.va[28:0]);
        if (a < 1021) begin
            model_mem[a] = r.wdata[7:0];
            if (r.bt != SZ_B) model_mem[a+1] = r.wdata[15:8];
            if (r.bt == SZ_W) begin
                model_mem[a+2] = r.wdata[23:16];
                model_mem[a+3] = r.wdata[31:24];
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
        checks++;
        assert (got === expv) else begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expv);
            errors++;
        end
    endtask

    task automatic check_fwd(input int i);
        row_t r;
        logic fv;
        int   e0;
        r = tbl[i];
        e0 = errors;
        fv = writes_rd(r.kind) && (r.rd != 5'd0) && !is_flush_kind(r.kind);
        check("fwd.valid", fwd.valid, fv);
        if (fv) begin
            check("fwd.idx", fwd.idx, r.rd);
            check("fwd.data_valid", fwd.data_valid, !is_load_kind(r.kind));
            if (r.kind == K_ALU) check("fwd.data", fwd.data, r.va);
        end
        if (is_flush_kind(r.kind)) begin
            $display("row %0d flushed: %s", i, (errors == e0) ? "ok" : "failed");
        end
    endtask

    task automatic compare_wb(input int i);
        row_t r;
        logic exc;
        logic wr;
        int   e0;
        r = tbl[i];
        e0 = errors;
        exc = (r.ecode != 6'h00);
        wr = writes_rd(r.kind);
        check("wb_out.pc", wb_out.pc, row_pc(i));
        check("excp_out.valid", excp_out.valid, exc);
        if (exc) begin
            check("excp_out.ecode", excp_out.ecode, r.ecode);
            check("excp_out.badv", excp_out.badv, r.va);
        end
        check("wb_out.is_wr_rd", wb_out.is_wr_rd, wr & ~exc);
        if (wr && !exc) begin
            check("wb_out.rd", wb_out.rd, r.rd);
            check("wb_out.data", wb_out.data, r.expd);
        end
        $display("row %0d pc %08h: %s", i, row_pc(i), (errors == e0) ? "ok" : "failed");
    endtask

    // sample at the falling edge, drive 2 ns after the rising edge
    task automatic tick();
        @(negedge clk);
        acc = rdy_in;
        if (fwd_row >= 0) begin
            check_fwd(fwd_row);
            fwd_row = -1;
        end
        if (fetch_req.valid && fetch_resp.done) begin
            check("fetch_resp.rdata", fetch_resp.rdata, fetch_exp);
            check("fetch_resp.err", fetch_resp.err, 1'b0);
            fetch_done = 1'b1;
        end
        assert (fetch_req.valid || !fetch_resp.done) else begin
            $display("fetch response arrived with no fetch pending");
            errors++;
        end
        @(posedge clk);
        #2;
        flush = 1'b0;
        if (fetch_done) begin
            fetch_req.valid = 1'b0;
            fetch_done = 1'b0;
            fetches++;
        end
        if (bp_left != 0) bp_left--;
        wb_ready = (bp_left == 0);
    endtask

    task automatic drive_row(input int i);
        row_t r;
        r = tbl[i];
        pass_in = '0;
        pass_in.valid = 1'b1;
        pass_in.pc = row_pc(i);
        pass_in.ex_out = r.va;
        pass_in.is_mem = (r.kind != K_ALU) && (r.kind != K_ALF);
        pass_in.is_store = (r.kind == K_ST) || (r.kind == K_STF);
        pass_in.is_signed = r.sgn;
        pass_in.byte_type = r.bt;
        pass_in.is_wr_rd = writes_rd(r.kind);
        pass_in.rd = r.rd;
        pass_in.rkd_data = r.wdata;
        excp_in = '0;
        if (r.kind == K_LDX) excp_in = '{valid: 1'b1, ecode: r.ecode, badv: r.va};
    endtask

    // results are consumed on edges where valid and wb_ready are both high
    always @(negedge clk) begin
        if (rst_n && wb_out.valid && wb_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("writeback appeared with no operation outstanding");
                errors++;
            end
            if (exp_q.size() > 0) compare_wb(exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        row_t r;
        rst_n = 1'b0;
        flush = 1'b0;
        wb_ready = 1'b1;
        pass_in = '0;
        excp_in = '0;
        fetch_req = '0;
        trans_cfg = '0;
        trans_cfg.dmw0 = '{en: 1'b1, vseg: 3'd4, pseg: 3'd0};

        // fetch region: words 0..3, written once by the first rows
        add_row(K_ST,  32'h8000_0000, SZ_W, 0, 32'ha1b2_c3d4, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0004, SZ_W, 0, 32'h1357_9bdf, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0008, SZ_W, 0, 32'h0246_8ace, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_000c, SZ_W, 0, 32'hcafe_f00d, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0010, SZ_W, 0, 32'h0000_0000, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0010, SZ_B, 0, 32'h0000_0081, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0011, SZ_B, 0, 32'h0000_0072, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0012, SZ_B, 0, 32'h0000_00f3, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0013, SZ_B, 0, 32'h0000_0004, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0014, SZ_W, 0, 32'hffff_ffff, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0014, SZ_H, 0, 32'h0000_8765, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ST,  32'h8000_0016, SZ_H, 0, 32'h0000_1234, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_LD,  32'h8000_0010, SZ_W, 0, 32'h0, 5'd1,  6'h00, 32'h04f3_7281, 0);
        add_row(K_LD,  32'h8000_0010, SZ_B, 1, 32'h0, 5'd2,  6'h00, 32'hffff_ff81, 0);
        add_row(K_LD,  32'h8000_0011, SZ_B, 1, 32'h0, 5'd3,  6'h00, 32'h0000_0072, 0);
        add_row(K_LD,  32'h8000_0012, SZ_B, 0, 32'h0, 5'd4,  6'h00, 32'h0000_00f3, 1);
        add_row(K_LD,  32'h8000_0012, SZ_B, 1, 32'h0, 5'd5,  6'h00, 32'hffff_fff3, 0);
        add_row(K_LD,  32'h8000_0013, SZ_B, 0, 32'h0, 5'd6,  6'h00, 32'h0000_0004, 0);
        add_row(K_LD,  32'h8000_0014, SZ_H, 1, 32'h0, 5'd7,  6'h00, 32'hffff_8765, 0);
        add_row(K_LD,  32'h8000_0014, SZ_H, 0, 32'h0, 5'd8,  6'h00, 32'h0000_8765, 0);
        add_row(K_LD,  32'h8000_0016, SZ_H, 1, 32'h0, 5'd9,  6'h00, 32'h0000_1234, 0);
        add_row(K_ALU, 32'hdead_beef, SZ_W, 0, 32'h0, 5'd10, 6'h00, 32'hdead_beef, 1);
        add_row(K_ALU, 32'h0000_0042, SZ_W, 0, 32'h0, 5'd0,  6'h00, 32'h0000_0042, 0);
        add_row(K_ST,  32'h8000_0015, SZ_H, 0, 32'h0000_aaaa, 5'd0, mem_pkg::ECODE_ALE, 32'h0, 0);
        add_row(K_LD,  32'h8000_0006, SZ_W, 0, 32'h0, 5'd11, mem_pkg::ECODE_ALE, 32'h0, 0);
        add_row(K_LD,  32'h0000_0010, SZ_W, 0, 32'h0, 5'd12, mem_pkg::ECODE_TLBR, 32'h0, 0);
        add_row(K_ST,  32'h0000_0014, SZ_W, 0, 32'h1111_1111, 5'd0, mem_pkg::ECODE_TLBR, 32'h0, 0);
        add_row(K_LD,  32'h8000_0400, SZ_W, 0, 32'h0, 5'd13, mem_pkg::ECODE_ADEM, 32'h0, 0);
        add_row(K_ST,  32'h8000_0404, SZ_W, 0, 32'h2222_2222, 5'd0, mem_pkg::ECODE_ADEM, 32'h0, 0);
        add_row(K_LDX, 32'h8000_0010, SZ_W, 0, 32'h0, 5'd14, 6'h0d, 32'h0, 0);
        add_row(K_STF, 32'h8000_0014, SZ_W, 0, 32'h5555_5555, 5'd0, 6'h00, 32'h0, 0);
        add_row(K_ALF, 32'h0000_0099, SZ_W, 0, 32'h0, 5'd15, 6'h00, 32'h0, 0);
        add_row(K_LD,  32'h8000_0014, SZ_W, 0, 32'h0, 5'd16, 6'h00, 32'h1234_8765, 1);
        add_row(K_ALU, 32'h1234_5678, SZ_W, 0, 32'h0, 5'd17, 6'h00, 32'h1234_5678, 0);
        add_row(K_LD,  32'h8000_000c, SZ_H, 1, 32'h0, 5'd18, 6'h00, 32'hffff_f00d, 0);
        add_row(K_LD,  32'h8000_000e, SZ_H, 0, 32'h0, 5'd19, 6'h00, 32'h0000_cafe, 0);
        add_row(K_LD,  32'h8000_0005, SZ_B, 1, 32'h0, 5'd20, 6'h00, 32'hffff_ff9b, 0);
        add_row(K_LD,  32'h8000_0000, SZ_W, 0, 32'h0, 5'd21, 6'h00, 32'ha1b2_c3d4, 0);
        limit = (tbl.size() * 16 + 16) * 2;

        repeat (16) @(posedge clk);
        #2;
        check("rdy_in", rdy_in, 1'b1);
        check("wb_out.valid", wb_out.valid, 1'b0);
        check("fwd.valid", fwd.valid, 1'b0);
        check("fetch_resp.done", fetch_resp.done, 1'b0);
        rst_n = 1'b1;

        for (int i = 0; i < tbl.size(); i++) begin
            r = tbl[i];
            drive_row(i);
            if (i >= 5 && !fetch_req.valid) begin
                rng = lcg_next(rng);
                if (rng[31:30] != 2'b00) begin
                    fetch_req.valid = 1'b1;
                    fetch_req.addr = {28'd0, rng[21:20], 2'b00};
                    fetch_exp = model_word(fetch_req.addr);
                end
            end
            do tick(); while (!acc);
            pass_in.valid = 1'b0;
            excp_in = '0;
            fwd_row = i;
            if (is_flush_kind(r.kind)) flush = 1'b1;  // kill it in its first cycle
            else exp_q.push_back(i);
            if (r.kind == K_ST && r.ecode == 6'h00) model_store(r);
            if (r.bp) begin
                bp_left = 6;
                wb_ready = 1'b0;
            end
        end

        while (exp_q.size() != 0 || fetch_req.valid) tick();
        repeat (8) tick();  // catch late duplicates

        $display("%0d rows, %0d fetches, %0d checks, %0d errors",
                 tbl.size(), fetches, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verification/mem_subsys_props.sv
`timescale 1ns/100ps

module mem_subsys_props (
    input logic                clk,
    input logic                rst_n,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input logic                pready,
    input mem_pkg::u32_t       paddr,
    input mem_pkg::u32_t       pwdata,
    input mem_pkg::mem_req_t   data_req,
    input mem_pkg::mem_resp_t  data_resp,
    input logic                flush
);

    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel && $past(psel && !penable))
        else $error("penable rose without a preceding setup cycle");

    // payload frozen from setup until pready
    apb_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else $error("APB address or data changed before pready");

    data_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        data_req.valid && !data_resp.done |=> data_req.valid)
        else $error("data request dropped before its response");

    no_flush_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        data_req.valid && !data_resp.done |=> !flush)
        else $error("flush raised while a data transfer was outstanding");

endmodule

bind mem_subsys_top mem_subsys_props props_i (
    .clk, .rst_n, .psel, .penable, .pwrite, .pready, .paddr, .pwdata,
    .data_req, .data_resp, .flush
);

//--- verilog/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  mem_pkg::exe_mem_pass_t pass_in,
    input  mem_pkg::excp_t         excp_in,
    input  mem_pkg::trans_cfg_t    trans_cfg,
    input  logic                   wb_ready,
    input  mem_pkg::fetch_req_t    fetch_req,
    output logic                   rdy_in,
    output mem_pkg::fwd_t          fwd,
    output mem_pkg::wb_t           wb_out,
    output mem_pkg::excp_t         excp_out,
    output mem_pkg::mem_resp_t     fetch_resp
);

    mem_pkg::mem_req_t        data_req;
    mem_pkg::mem_resp_t       data_resp;
    mem_pkg::mem1_mem2_pass_t m1_pass;
    mem_pkg::excp_t           m1_excp;
    logic                     mem2_ready;

    // apb bus
    logic          psel;
    logic          penable;
    logic          pwrite;
    mem_pkg::u32_t paddr;
    mem_pkg::u32_t pwdata;
    logic [3:0]    pstrb;
    mem_pkg::u32_t prdata;
    logic          pready;
    logic          pslverr;

    mem1_stage mem1_i (
        .clk, .rst_n, .flush, .pass_in, .excp_in,
        .cfg         (trans_cfg),
        .data_resp,
        .next_rdy_in (mem2_ready),
        .rdy_in, .fwd, .data_req,
        .pass_out    (m1_pass),
        .excp_out    (m1_excp)
    );

    mem2_stage mem2_i (
        .clk, .rst_n,
        .pass_in  (m1_pass),
        .excp_in  (m1_excp),
        .wb_ready,
        .rdy_in   (mem2_ready),
        .wb_out, .excp_out
    );

    apb_arbiter arb_i (
        .clk, .rst_n, .data_req, .fetch_req,
        .prdata, .pready, .pslverr,
        .data_resp, .fetch_resp,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb
    );

    apb_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .prdata, .pready, .pslverr
    );

endmodule

//--- verilog/apb_ram.sv
`timescale 1ns/100ps

module apb_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  mem_pkg::u32_t paddr,
    input  mem_pkg::u32_t pwdata,
    input  logic [3:0]    pstrb,
    output mem_pkg::u32_t prdata,
    output logic          pready,
    output logic          pslverr
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    mem_pkg::u32_t mem [RAM_WORDS];

    logic             wait_q;   // first access cycle seen
    logic [29:0]      word_idx;
    logic [IDX_W-1:0] ram_idx;
    logic             in_range;

    assign word_idx = paddr[31:2];
    assign ram_idx  = word_idx[IDX_W-1:0];
    assign in_range = (word_idx < 30'(RAM_WORDS));

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= psel & penable & ~wait_q;
        end
    end

    assign pready  = psel & penable & wait_q;
    assign pslverr = pready & ~in_range;
    assign prdata  = (pready & in_range) ? mem[ram_idx] : '0;

    always_ff @(posedge clk) begin
        if (pready & pwrite & in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[ram_idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/apb_arbiter.sv
`timescale 1ns/100ps

module apb_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_pkg::mem_req_t    data_req,
    input  mem_pkg::fetch_req_t  fetch_req,
    input  mem_pkg::u32_t        prdata,
    input  logic                 pready,
    input  logic                 pslverr,
    output mem_pkg::mem_resp_t   data_resp,
    output mem_pkg::mem_resp_t   fetch_resp,
    output logic                 psel,
    output logic                 penable,
    output logic                 pwrite,
    output mem_pkg::u32_t        paddr,
    output mem_pkg::u32_t        pwdata,
    output logic [3:0]           pstrb
);

    mem_pkg::arb_state_e state;
    logic                last_fetch;   // last grant went to fetch
    logic                grant_fetch;
    logic                pick_fetch;
    logic                xfer_end;

    // fetch wins a tie only when data was served last
    assign pick_fetch = fetch_req.valid & (~data_req.valid | ~last_fetch);
    assign xfer_end   = (state == mem_pkg::ARB_ACCESS) & pready;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= mem_pkg::ARB_IDLE;
            last_fetch <= 1'b0;
        end else begin
            case (state)
                mem_pkg::ARB_IDLE: begin
                    if (data_req.valid | fetch_req.valid) begin
                        state <= mem_pkg::ARB_SETUP;
                    end
                end
                mem_pkg::ARB_SETUP: state <= mem_pkg::ARB_ACCESS;
                mem_pkg::ARB_ACCESS: begin
                    if (pready) begin
                        state      <= mem_pkg::ARB_IDLE;
                        last_fetch <= grant_fetch;
                    end
                end
                default: state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    // transfer payload, held from grant until pready
    always_ff @(posedge clk) begin
        if (state == mem_pkg::ARB_IDLE) begin
            grant_fetch <= pick_fetch;
            if (pick_fetch) begin
                pwrite <= 1'b0;
                paddr  <= fetch_req.addr;
                pwdata <= '0;
                pstrb  <= 4'b0000;
            end else begin
                pwrite <= data_req.write;
                paddr  <= data_req.addr;
                pwdata <= data_req.wdata;
                pstrb  <= data_req.wstrb;
            end
        end
    end

    assign psel    = (state != mem_pkg::ARB_IDLE);
    assign penable = (state == mem_pkg::ARB_ACCESS);

    always_comb begin
        data_resp.done   = xfer_end & ~grant_fetch;
        data_resp.rdata  = prdata;
        data_resp.err    = pslverr;
        fetch_resp.done  = xfer_end & grant_fetch;
        fetch_resp.rdata = prdata;
        fetch_resp.err   = pslverr;
    end

endmodule

//--- verilog/mem2_stage.sv
`timescale 1ns/100ps

module mem2_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_pkg::mem1_mem2_pass_t pass_in,
    input  mem_pkg::excp_t           excp_in,
    input  logic                     wb_ready,
    output logic                     rdy_in,
    output mem_pkg::wb_t             wb_out,
    output mem_pkg::excp_t           excp_out
);

    mem_pkg::wb_t   wb_q;
    mem_pkg::excp_t excp_q;

    logic          is_load;
    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    mem_pkg::u32_t ld_data;
    mem_pkg::u32_t result;

    assign is_load = pass_in.is_mem & ~pass_in.is_store;

    always_comb begin
        ld_byte = pass_in.rdata[8*pass_in.ex_out[1:0] +: 8];
        ld_half = pass_in.ex_out[1] ? pass_in.rdata[31:16] : pass_in.rdata[15:0];
        case (pass_in.byte_type)
            mem_pkg::BYTE:
                ld_data = {{24{pass_in.is_signed & ld_byte[7]}}, ld_byte};
            mem_pkg::HALF_WORD:
                ld_data = {{16{pass_in.is_signed & ld_half[15]}}, ld_half};
            default:
                ld_data = pass_in.rdata;
        endcase
    end

    assign result = is_load ? ld_data : pass_in.ex_out;

    // space whenever the register drains this cycle
    assign rdy_in = ~wb_q.valid | wb_ready;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wb_q.valid   <= 1'b0;
            excp_q.valid <= 1'b0;
        end else if (rdy_in) begin
            wb_q.valid    <= pass_in.valid;
            wb_q.pc       <= pass_in.pc;
            wb_q.is_wr_rd <= pass_in.is_wr_rd & ~excp_in.valid; // no write on exception
            wb_q.rd       <= pass_in.rd;
            wb_q.data     <= result;
            excp_q.valid  <= pass_in.valid & excp_in.valid;
            excp_q.ecode  <= excp_in.ecode;
            excp_q.badv   <= excp_in.badv;
        end
    end

    assign wb_out   = wb_q;
    assign excp_out = excp_q;

endmodule

//--- verilog/mem1_stage.sv
`timescale 1ns/100ps

module mem1_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  mem_pkg::exe_mem_pass_t   pass_in,
    input  mem_pkg::excp_t           excp_in,
    input  mem_pkg::trans_cfg_t      cfg,
    input  mem_pkg::mem_resp_t       data_resp,
    input  logic                     next_rdy_in,
    output logic                     rdy_in,
    output mem_pkg::fwd_t            fwd,
    output mem_pkg::mem_req_t        data_req,
    output mem_pkg::mem1_mem2_pass_t pass_out,
    output mem_pkg::excp_t           excp_out
);

    mem_pkg::exe_mem_pass_t pass_r;
    mem_pkg::excp_t         excp_r;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pass_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_r <= pass_in;  // bubbles load too
            excp_r <= excp_in;
        end
    end

    logic mem1_flush;
    logic mem1_stall;
    logic rdy_out;
    logic need_req;
    logic mem_wait;

    mem_pkg::u32_t  pa;
    mem_pkg::excp_t addr_excp;

    addr_trans addr_trans_i (
        .en        (~mem1_flush & pass_r.is_mem),
        .va        (pass_r.ex_out),
        .is_store  (pass_r.is_store),
        .byte_type (pass_r.byte_type),
        .cfg       (cfg),
        .pa        (pa),
        .excp      (addr_excp)
    );

    // response capture, so the request is issued once per op
    logic          done_q;
    logic          err_q;
    mem_pkg::u32_t rdata_q;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (rdy_in) begin
            done_q <= 1'b0;
        end else if (data_resp.done) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_resp.done) begin
            rdata_q <= data_resp.rdata;
            err_q   <= data_resp.err;
        end
    end

    assign mem1_flush = flush | ~pass_r.valid;
    assign need_req   = ~mem1_flush & pass_r.is_mem & ~excp_r.valid & ~addr_excp.valid;
    assign mem_wait   = need_req & ~done_q & ~data_resp.done;
    assign mem1_stall = ~next_rdy_in | mem_wait;

    assign rdy_in  = mem1_flush | ~mem1_stall;
    assign rdy_out = ~mem1_flush & ~mem1_stall;

    mem_pkg::u32_t resp_rdata;
    logic          resp_err;
    assign resp_rdata = done_q ? rdata_q : data_resp.rdata;
    assign resp_err   = need_req & (done_q ? err_q : data_resp.err);

    // store lane placement
    mem_pkg::u32_t st_data;
    logic [3:0]    st_strb;

    always_comb begin
        st_data = pass_r.rkd_data;
        st_strb = 4'b1111;
        case (pass_r.byte_type)
            mem_pkg::BYTE: begin
                st_data = {4{pass_r.rkd_data[7:0]}};
                st_strb = 4'b0001 << pa[1:0];
            end
            mem_pkg::HALF_WORD: begin
                st_data = {2{pass_r.rkd_data[15:0]}};
                st_strb = pa[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    always_comb begin
        data_req.valid = need_req & ~done_q;
        data_req.write = pass_r.is_store;
        data_req.addr  = pa;
        data_req.wdata = st_data;
        data_req.wstrb = pass_r.is_store ? st_strb : 4'b0000;
    end

    // loads cannot hand data to the bypass yet
    always_comb begin
        fwd.valid      = (pass_r.rd != 5'd0) & pass_r.is_wr_rd & ~mem1_flush;
        fwd.idx        = pass_r.rd;
        fwd.data_valid = ~(pass_r.is_mem & ~pass_r.is_store);
        fwd.data       = pass_r.ex_out;
    end

    always_comb begin
        pass_out.valid     = rdy_out;
        pass_out.pc        = pass_r.pc;
        pass_out.ex_out    = pass_r.ex_out;
        pass_out.is_mem    = pass_r.is_mem;
        pass_out.is_store  = pass_r.is_store;
        pass_out.is_signed = pass_r.is_signed;
        pass_out.byte_type = pass_r.byte_type;
        pass_out.is_wr_rd  = pass_r.is_wr_rd;
        pass_out.rd        = pass_r.rd;
        pass_out.rdata     = resp_rdata;
    end

    always_comb begin
        excp_out       = addr_excp;
        excp_out.valid = 1'b0;
        if (rdy_out) begin
            if (excp_r.valid) begin
                excp_out = excp_r;
            end else if (addr_excp.valid) begin
                excp_out = addr_excp;
            end else if (resp_err) begin
                excp_out.valid = 1'b1;
                excp_out.ecode = mem_pkg::ECODE_ADEM;
                excp_out.badv  = pass_r.ex_out;
            end
        end
    end

endmodule

//--- verilog/addr_trans.sv
`timescale 1ns/100ps

module addr_trans (
    input  logic                 en,
    input  mem_pkg::u32_t        va,
    input  logic                 is_store,
    input  mem_pkg::byte_type_e  byte_type,
    input  mem_pkg::trans_cfg_t  cfg,
    output mem_pkg::u32_t        pa,
    output mem_pkg::excp_t       excp
);

    logic hit0;
    logic hit1;
    logic win_miss;
    logic misaligned;

    // only the top segment bits take part in the window match
    assign hit0 = cfg.dmw0.en && (va[31:29] == cfg.dmw0.vseg);
    assign hit1 = cfg.dmw1.en && (va[31:29] == cfg.dmw1.vseg);
    assign win_miss = ~cfg.da & ~hit0 & ~hit1;

    always_comb begin
        pa = va;
        if (!cfg.da) begin
            if (hit0) begin
                pa = {cfg.dmw0.pseg, va[28:0]};
            end else if (hit1) begin
                pa = {cfg.dmw1.pseg, va[28:0]};
            end
        end
    end

    always_comb begin
        misaligned = 1'b0;
        case (byte_type)
            mem_pkg::HALF_WORD: misaligned = va[0];
            mem_pkg::WORD:      misaligned = |va[1:0];
            default:            misaligned = 1'b0;
        endcase
    end

    always_comb begin
        excp.valid = en & (misaligned | win_miss);
        excp.ecode = misaligned ? mem_pkg::ECODE_ALE : mem_pkg::ECODE_TLBR; // ale wins
        excp.badv  = va;
    end

endmodule

//--- verilog/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  ecode_t;

    localparam ecode_t ECODE_ALE  = 6'h09;  // misaligned access
    localparam ecode_t ECODE_TLBR = 6'h3f;  // no direct window hit
    localparam ecode_t ECODE_ADEM = 6'h08;  // bus error

    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_e;

    typedef struct packed {
        logic       en;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic da;   // pa equals va
        dmw_t dmw0;
        dmw_t dmw1;
    } trans_cfg_t;

    typedef struct packed {
        logic   valid;
        ecode_t ecode;
        u32_t   badv;
    } excp_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_e byte_type;
        logic       is_wr_rd;
        reg_idx_t   rd;
        u32_t       rkd_data;
    } exe_mem_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        logic     data_valid;
        u32_t     data;
    } fwd_t;

    typedef struct packed {
        logic       valid;
        logic       write;
        u32_t       addr;
        u32_t       wdata;
        logic [3:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic done;
        u32_t rdata;
        logic err;
    } mem_resp_t;

    typedef struct packed {
        logic valid;
        u32_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        u32_t       pc;
        u32_t       ex_out;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_e byte_type;
        logic       is_wr_rd;
        reg_idx_t   rd;
        u32_t       rdata;
    } mem1_mem2_pass_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        logic     is_wr_rd;
        reg_idx_t rd;
        u32_t     data;
    } wb_t;

    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_SETUP  = 2'd1,
        ARB_ACCESS = 2'd2
    } arb_state_e;

endpackage
